// ==== hdl/fetch_pkg.sv ====
package fetch_pkg;

    // first fetch address out of reset
    localparam logic [31:0] pc_reset = 32'h1c00_0000;
    // andi r0, r0, 0
    localparam logic [31:0] inst_nop = 32'h0340_0000;

    // instruction queue sizing
    localparam int queue_depth = 8;
    localparam int queue_aw = $clog2(queue_depth);
    // room for the packet in the stage plus the request on the bus
    localparam int space_need = 2;

    // top 10 opcode bits of the serializing classes
    localparam logic [9:0] op_ibar = 10'h0e1;
    localparam logic [9:0] op_csr = 10'h010;
    localparam logic [9:0] op_tlb = 10'h019;

    // 3R-style register view of an instruction
    typedef struct packed {
        logic [9:0] op;
        logic [6:0] mid;
        logic [4:0] rk;
        logic [4:0] rj;
        logic [4:0] rd;
    } inst_fields_t;

    typedef union packed {
        logic [31:0] raw;
        inst_fields_t fields;
    } inst_word_u;

    // one fetch group as it sits in the queue
    typedef struct packed {
        logic [31:0] pc;
        inst_word_u inst0;
        inst_word_u inst1;
        logic [1:0] slot_valid;
        logic [6:0] excp;
        logic [1:0] excp_flag;
        logic [31:0] badv;
    } fetch_pkt_t;

    // raw icache answer, always both words of the 8-byte line chunk
    typedef struct packed {
        inst_word_u inst0;
        inst_word_u inst1;
        logic [6:0] excp;
        logic [1:0] excp_flag;
        logic [31:0] badv;
    } icache_resp_t;

    typedef enum logic [2:0] {
        idle = 3'b000,
        wait_ex_ibar = 3'b001,
        wait_ex_csr = 3'b010,
        wait_cache_idle = 3'b011,
        wait_csr_ok = 3'b100,
        wait_tlb_ok = 3'b101,
        wait_ex_tlb = 3'b111
    } bar_state_t;

    typedef struct packed {
        logic [31:0] pc;
        inst_word_u inst;
        logic [4:0] rd;
        logic [4:0] rj;
        logic [4:0] rk;
        logic [6:0] excp;
        logic [1:0] excp_flag;
        logic [31:0] badv;
    } issue_t;

endpackage

// ==== hdl/fetch_pc_gen.sv ====
`timescale 1ns/1ns

module fetch_pc_gen (
    input  logic        clk,
    input  logic        rstn,
    input  logic        flush,
    input  logic [31:0] redirect_pc,
    input  logic        resume,
    input  logic [31:0] resume_pc,
    input  logic        fetch_allowin,
    output logic        fetch_req,
    output logic [31:0] fetch_addr
);
    import fetch_pkg::*;

    // address of the next request
    logic [31:0] pc;
    logic [31:0] pc_seq;
    logic        take;

    // sequential fetch continues at the next aligned 8-byte group
    assign pc_seq = {pc[31:3] + 29'd1, 3'b000};

    // no request while the pc is being redirected
    assign take = fetch_allowin && !flush && !resume;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pc <= pc_reset;
        end else if (flush) begin
            pc <= redirect_pc;
        end else if (resume) begin
            // restart behind the barrier
            pc <= resume_pc;
        end else if (take) begin
            pc <= pc_seq;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            fetch_req <= 1'b0;
        end else begin
            fetch_req <= take;
        end
    end

    // address goes out with the request, may carry bit 2 after a redirect
    always_ff @(posedge clk) begin
        if (take) begin
            fetch_addr <= pc;
        end
    end

endmodule

// ==== hdl/fetch_stage_reg.sv ====
`timescale 1ns/1ns

module fetch_stage_reg (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     flush,
    input  logic                     fetch_req,
    input  logic [31:0]              fetch_addr,
    input  logic                     resp_valid,
    input  fetch_pkg::icache_resp_t  resp,
    input  logic                     space_ok,
    input  logic                     queue_full,
    input  logic                     ibar_from_ex,
    input  logic                     csr_from_ex,
    input  logic                     tlb_from_ex,
    input  logic                     cache_idle,
    input  logic                     csr_done,
    input  logic                     tlb_done,
    output logic                     fetch_allowin,
    output logic                     push,
    output fetch_pkg::fetch_pkt_t    pkt,
    output logic                     resume,
    output logic [31:0]              resume_pc
);
    import fetch_pkg::*;

    // request on the bus, tag dropped by flush
    logic        inflight;
    logic [31:0] req_pc;
    logic        pkt_valid;
    logic        load;
    bar_state_t  bar_state;
    bar_state_t  bar_next;
    bar_state_t  ser_state;
    inst_word_u  slot_w [2];
    logic [1:0]  slot_v;
    logic [1:0]  is_ser;
    logic        ser_slot;
    logic [1:0]  keep;

    // response only counts if its request survived any flush
    assign load = resp_valid && inflight && !flush;
    assign push = pkt_valid && !queue_full;
    assign fetch_allowin = space_ok && (bar_state == idle) && !resume && !flush
                           && !fetch_req && !inflight;

    // align by pc bit 2 and pre-decode both slots
    always_comb begin
        slot_w[0] = req_pc[2] ? resp.inst1 : resp.inst0;
        slot_w[1] = req_pc[2] ? inst_word_u'(inst_nop) : resp.inst1;
        slot_v = req_pc[2] ? 2'b01 : 2'b11;
        for (int i = 0; i < 2; i++) begin
            is_ser[i] = slot_v[i] && (slot_w[i].fields.op == op_ibar
                                      || slot_w[i].fields.op == op_csr
                                      || slot_w[i].fields.op == op_tlb);
        end
        // oldest serializing slot wins
        ser_slot = !is_ser[0];
        keep = is_ser[0] ? 2'b01 : slot_v;
        if (slot_w[ser_slot].fields.op == op_ibar) begin
            ser_state = wait_ex_ibar;
        end else if (slot_w[ser_slot].fields.op == op_csr) begin
            ser_state = wait_ex_csr;
        end else begin
            ser_state = wait_ex_tlb;
        end
    end

    // barrier wait FSM
    always_comb begin
        bar_next = bar_state;
        case (bar_state)
            idle: begin
                if (load && is_ser != 2'b00) begin
                    bar_next = ser_state;
                end
            end
            wait_ex_ibar: if (ibar_from_ex) bar_next = wait_cache_idle;
            wait_ex_csr: if (csr_from_ex) bar_next = wait_csr_ok;
            wait_ex_tlb: if (tlb_from_ex) bar_next = wait_tlb_ok;
            wait_cache_idle: if (cache_idle) bar_next = idle;
            wait_csr_ok: if (csr_done) bar_next = idle;
            wait_tlb_ok: if (tlb_done) bar_next = idle;
            default: bar_next = idle;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            inflight <= 1'b0;
            pkt_valid <= 1'b0;
            bar_state <= idle;
            resume <= 1'b0;
        end else if (flush) begin
            inflight <= 1'b0;
            pkt_valid <= 1'b0;
            bar_state <= idle;
            resume <= 1'b0;
        end else begin
            if (fetch_req) begin
                inflight <= 1'b1;
            end else if (resp_valid) begin
                inflight <= 1'b0;
            end
            pkt_valid <= load || (pkt_valid && !push);
            bar_state <= bar_next;
            // single pulse on the way back to idle
            resume <= (bar_state != idle) && (bar_next == idle);
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if (fetch_req) begin
            req_pc <= fetch_addr;
        end
        if (load) begin
            pkt.pc <= req_pc;
            pkt.inst0 <= slot_w[0];
            pkt.inst1 <= keep[1] ? slot_w[1] : inst_word_u'(inst_nop);
            pkt.slot_valid <= keep;
            pkt.excp <= resp.excp;
            pkt.excp_flag <= resp.excp_flag;
            pkt.badv <= resp.badv;
        end
        if (load && is_ser != 2'b00) begin
            // restart right behind the barrier instruction
            resume_pc <= req_pc + {29'd0, ser_slot, 2'b00} + 32'd4;
        end
    end

endmodule

// ==== hdl/inst_queue.sv ====
`timescale 1ns/1ns

module inst_queue (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   flush,
    input  logic                   push,
    input  fetch_pkg::fetch_pkt_t  pkt,
    input  logic                   pop,
    output fetch_pkg::fetch_pkt_t  head_pkt,
    output logic                   not_empty,
    output logic                   queue_full,
    output logic                   space_ok
);
    import fetch_pkg::*;

    fetch_pkt_t            mem [queue_depth];
    logic [queue_aw-1:0]   wr_ptr;
    logic [queue_aw-1:0]   rd_ptr;
    // one extra bit so full and empty differ
    logic [queue_aw:0]     count;
    logic                  do_push;
    logic                  do_pop;

    assign do_push = push && !queue_full && !flush;
    assign do_pop = pop && not_empty && !flush;

    assign head_pkt = mem[rd_ptr];
    assign not_empty = count != '0;
    assign queue_full = count == (queue_aw + 1)'(queue_depth);
    // enough room for the stage packet and the request on the bus
    assign space_ok = count <= (queue_aw + 1)'(queue_depth - space_need);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            // pointers wrap naturally at a power of two depth
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= pkt;
        end
    end

endmodule

// ==== hdl/decode_issue.sv ====
`timescale 1ns/1ns

module decode_issue (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   flush,
    input  fetch_pkg::fetch_pkt_t  head_pkt,
    input  logic                   not_empty,
    input  logic                   issue_ready,
    output logic                   pop,
    output logic                   issue_valid,
    output fetch_pkg::issue_t      issue
);
    import fetch_pkg::*;

    // slot of the head packet to issue next
    logic        idx;
    logic        cur;
    logic        has;
    logic        last;
    logic        take;
    logic [31:0] slot_pc;
    inst_word_u  slot_inst;
    logic        excp_hit;

    // skip an invalid slot 0
    assign cur = idx || !head_pkt.slot_valid[0];
    assign has = head_pkt.slot_valid[cur];
    assign last = cur || !head_pkt.slot_valid[1];
    // output register free or being drained
    assign take = not_empty && (!issue_valid || issue_ready) && !flush;
    assign pop = take && last;

    assign slot_pc = head_pkt.pc + {29'd0, cur, 2'b00};
    assign slot_inst = cur ? head_pkt.inst1 : head_pkt.inst0;
    // fault belongs to the slot at badv only
    assign excp_hit = slot_pc == head_pkt.badv;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            idx <= 1'b0;
            issue_valid <= 1'b0;
        end else if (flush) begin
            idx <= 1'b0;
            issue_valid <= 1'b0;
        end else if (take) begin
            idx <= !last;
            issue_valid <= has;
        end else if (issue_ready) begin
            issue_valid <= 1'b0;
        end
    end

    // hold while stalled
    always_ff @(posedge clk) begin
        if (take && has) begin
            issue.pc <= slot_pc;
            issue.inst <= slot_inst;
            issue.rd <= slot_inst.fields.rd;
            issue.rj <= slot_inst.fields.rj;
            issue.rk <= slot_inst.fields.rk;
            issue.excp <= excp_hit ? head_pkt.excp : 7'd0;
            issue.excp_flag <= excp_hit ? head_pkt.excp_flag : 2'd0;
            issue.badv <= head_pkt.badv;
        end
    end

endmodule

// ==== hdl/frontend_top.sv ====
`timescale 1ns/1ns

module frontend_top (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     flush,
    input  logic [31:0]              redirect_pc,
    output logic                     fetch_req,
    output logic [31:0]              fetch_addr,
    input  logic                     resp_valid,
    input  fetch_pkg::icache_resp_t  resp,
    input  logic                     ibar_from_ex,
    input  logic                     csr_from_ex,
    input  logic                     tlb_from_ex,
    input  logic                     cache_idle,
    input  logic                     csr_done,
    input  logic                     tlb_done,
    input  logic                     issue_ready,
    output logic                     issue_valid,
    output fetch_pkg::issue_t        issue
);
    import fetch_pkg::*;

    logic        fetch_allowin;
    logic        resume;
    logic [31:0] resume_pc;
    // stage to queue
    logic        push;
    fetch_pkt_t  pkt;
    logic        queue_full;
    logic        space_ok;
    // queue to consumer
    fetch_pkt_t  head_pkt;
    logic        not_empty;
    logic        pop;

    fetch_pc_gen u_pc_gen (
        .clk(clk), .rstn(rstn), .flush(flush), .redirect_pc(redirect_pc),
        .resume(resume), .resume_pc(resume_pc), .fetch_allowin(fetch_allowin),
        .fetch_req(fetch_req), .fetch_addr(fetch_addr)
    );

    fetch_stage_reg u_stage (
        .clk(clk), .rstn(rstn), .flush(flush),
        .fetch_req(fetch_req), .fetch_addr(fetch_addr),
        .resp_valid(resp_valid), .resp(resp),
        .space_ok(space_ok), .queue_full(queue_full),
        .ibar_from_ex(ibar_from_ex), .csr_from_ex(csr_from_ex), .tlb_from_ex(tlb_from_ex),
        .cache_idle(cache_idle), .csr_done(csr_done), .tlb_done(tlb_done),
        .fetch_allowin(fetch_allowin), .push(push), .pkt(pkt),
        .resume(resume), .resume_pc(resume_pc)
    );

    inst_queue u_queue (
        .clk(clk), .rstn(rstn), .flush(flush), .push(push), .pkt(pkt), .pop(pop),
        .head_pkt(head_pkt), .not_empty(not_empty), .queue_full(queue_full),
        .space_ok(space_ok)
    );

    decode_issue u_issue (
        .clk(clk), .rstn(rstn), .flush(flush), .head_pkt(head_pkt),
        .not_empty(not_empty), .issue_ready(issue_ready), .pop(pop),
        .issue_valid(issue_valid), .issue(issue)
    );

endmodule

// ==== tests/frontend_tb.sv ====
`timescale 1ns/1ns

module frontend_tb;
    import fetch_pkg::*;

    // per-test cycle budgets summed for the watchdog
    localparam int reset_cycles = 10;
    localparam int budget_cycles = reset_cycles + 200 + 400 + 200 + 300 + 600 + 150;
    localparam int issue_limit = 200;
    // constant mixed into every memory word
    localparam logic [31:0] mem_mix = 32'h5a3c_9e17;
    // flag value the cache returns with a fault
    localparam logic [1:0] fault_flag = 2'b01;

    logic         clk;
    logic         rstn;
    logic         flush;
    logic [31:0]  redirect_pc;
    logic         fetch_req;
    logic [31:0]  fetch_addr;
    logic         resp_valid;
    icache_resp_t resp;
    logic         ibar_from_ex;
    logic         csr_from_ex;
    logic         tlb_from_ex;
    logic         cache_idle;
    logic         csr_done;
    logic         tlb_done;
    logic         issue_ready;
    logic         issue_valid;
    issue_t       issue;

    // request seen last cycle and answered in this one
    logic         pend_req;
    logic [31:0]  pend_addr;
    // one serializing word and one faulting address per test
    logic         ser_en;
    logic [31:0]  ser_addr;
    logic [9:0]   ser_op;
    logic         excp_en;
    logic [31:0]  excp_addr;
    logic [6:0]   excp_code;
    logic         rand_ready;
    logic [31:0]  rnd;
    logic [31:0]  exp_pc;

    frontend_top dut (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // memory content is the rotated address mixed with a constant
    function automatic logic [31:0] mem_word(input logic [31:0] a);
        logic [31:0] mix;
        mix = {a[13:0], a[31:14]} ^ mem_mix;
        if (ser_en && a == ser_addr) begin
            return {ser_op, mix[21:0]};
        end
        // top bits 2'b10 keep ordinary words away from the barrier opcodes
        return {2'b10, mix[29:0]};
    endfunction

    // icache model answering one cycle after each request without stalls
    always @(posedge clk) begin
        #5;
        resp_valid = pend_req;
        if (pend_req) begin
            resp.inst0.raw = mem_word({pend_addr[31:3], 3'b000});
            resp.inst1.raw = mem_word({pend_addr[31:3], 3'b100});
            if (excp_en && excp_addr[31:3] == pend_addr[31:3]) begin
                resp.excp = excp_code;
                resp.excp_flag = fault_flag;
                resp.badv = excp_addr;
            end else begin
                resp.excp = 7'd0;
                resp.excp_flag = 2'b00;
                resp.badv = 32'd0;
            end
        end
        pend_req = fetch_req;
        pend_addr = fetch_addr;
    end

    // random consumer stalls
    always @(posedge clk) begin
        #5;
        if (rand_ready) begin
            rnd = $urandom();
            issue_ready = rnd[0];
        end
    end

    initial begin
        repeat (budget_cycles * 4) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles", budget_cycles * 4);
        $display("SOME TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

    task automatic report_mismatch(input string name, input string what,
                                   input logic [31:0] exp, input logic [31:0] act);
        $display("Fail %s: %s expected %h actual %h", name, what, exp, act);
        $display("SOME TESTS FAILED");
        $fatal(1, "%s stopped on a %s mismatch", name, what);
    endtask

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic tick();
        @(posedge clk);
        #5;
    endtask

    // next accepted instruction sampled mid cycle
    task automatic next_issue(input string name, output issue_t it);
        int waited;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!(issue_valid && issue_ready) && waited < issue_limit);
        assert (issue_valid && issue_ready)
            else report_error($sformatf("%s: nothing issued for %0d cycles", name, issue_limit));
        it = issue;
    endtask

    // scoreboard expects exp_pc and then moves to the next word
    task automatic check_next(input string name);
        issue_t      it;
        logic [31:0] word;
        logic        hit;
        logic [1:0]  flag;
        next_issue(name, it);
        word = mem_word(exp_pc);
        hit = excp_en && exp_pc == excp_addr;
        flag = hit ? fault_flag : 2'b00;
        assert (it.pc == exp_pc) else report_mismatch(name, "pc", exp_pc, it.pc);
        assert (it.inst.raw == word) else report_mismatch(name, "inst", word, it.inst.raw);
        assert (it.rd == word[4:0]) else report_mismatch(name, "rd", 32'(word[4:0]), 32'(it.rd));
        assert (it.rj == word[9:5]) else report_mismatch(name, "rj", 32'(word[9:5]), 32'(it.rj));
        assert (it.rk == word[14:10])
            else report_mismatch(name, "rk", 32'(word[14:10]), 32'(it.rk));
        assert (it.excp == (hit ? excp_code : 7'd0))
            else report_mismatch(name, "excp", 32'(hit ? excp_code : 7'd0), 32'(it.excp));
        assert (it.excp_flag == flag)
            else report_mismatch(name, "excp_flag", 32'(flag), 32'(it.excp_flag));
        if (hit) begin
            assert (it.badv == exp_pc) else report_mismatch(name, "badv", exp_pc, it.badv);
        end
        exp_pc = exp_pc + 32'd4;
    endtask

    task automatic expect_quiet(input string name, input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            assert (!(issue_valid && issue_ready))
                else report_error($sformatf("%s: pc %h issued behind a barrier", name, issue.pc));
        end
    endtask

    task automatic redirect_to(input logic [31:0] addr);
        tick();
        flush = 1'b1;
        redirect_pc = addr;
        tick();
        flush = 1'b0;
        exp_pc = addr;
    endtask

    // execute flag alone must not restart fetch before the completion
    task automatic release_barrier(input int kind, input string name);
        tick();
        ibar_from_ex = (kind == 0);
        csr_from_ex = (kind == 1);
        tlb_from_ex = (kind == 2);
        tick();
        ibar_from_ex = 1'b0;
        csr_from_ex = 1'b0;
        tlb_from_ex = 1'b0;
        expect_quiet(name, 10);
        tick();
        cache_idle = (kind == 0);
        csr_done = (kind == 1);
        tlb_done = (kind == 2);
        tick();
        cache_idle = 1'b0;
        csr_done = 1'b0;
        tlb_done = 1'b0;
    endtask

    task automatic test_stream();
        repeat (40) check_next("test_stream");
    endtask

    task automatic test_backpressure();
        rand_ready = 1'b1;
        repeat (60) check_next("test_backpressure");
        rand_ready = 1'b0;
        tick();
        issue_ready = 1'b1;
    endtask

    task automatic test_redirect();
        // bit 2 set so the first group has one slot
        redirect_to(32'h1c00_2004);
        repeat (20) check_next("test_redirect");
    endtask

    task automatic test_ibar();
        ser_en = 1'b1;
        ser_addr = 32'h1c00_1014;
        ser_op = op_ibar;
        redirect_to(32'h1c00_1000);
        repeat (6) check_next("test_ibar");
        expect_quiet("test_ibar", 30);
        release_barrier(0, "test_ibar");
        repeat (8) check_next("test_ibar");
        ser_en = 1'b0;
    endtask

    task automatic test_csr_tlb();
        // csr in slot 0 drops slot 1
        ser_en = 1'b1;
        ser_addr = 32'h1c00_3020;
        ser_op = op_csr;
        redirect_to(32'h1c00_3000);
        repeat (9) check_next("test_csr_tlb");
        expect_quiet("test_csr_tlb", 30);
        // fetch is stopped and the tlb word further on not yet read
        ser_addr = 32'h1c00_303c;
        ser_op = op_tlb;
        release_barrier(1, "test_csr_tlb");
        repeat (7) check_next("test_csr_tlb");
        expect_quiet("test_csr_tlb", 30);
        release_barrier(2, "test_csr_tlb");
        repeat (6) check_next("test_csr_tlb");
        ser_en = 1'b0;
    endtask

    task automatic test_excp();
        excp_en = 1'b1;
        excp_addr = 32'h1c00_401c;
        excp_code = 7'h08;
        redirect_to(32'h1c00_4000);
        repeat (12) check_next("test_excp");
        excp_en = 1'b0;
    endtask

    initial begin
        void'($urandom(32'hb391_c4c7));
        rstn = 1'b0;
        flush = 1'b0;
        redirect_pc = 32'd0;
        resp_valid = 1'b0;
        resp = '0;
        ibar_from_ex = 1'b0;
        csr_from_ex = 1'b0;
        tlb_from_ex = 1'b0;
        cache_idle = 1'b0;
        csr_done = 1'b0;
        tlb_done = 1'b0;
        issue_ready = 1'b1;
        pend_req = 1'b0;
        pend_addr = 32'd0;
        ser_en = 1'b0;
        ser_addr = 32'd0;
        ser_op = 10'd0;
        excp_en = 1'b0;
        excp_addr = 32'd0;
        excp_code = 7'd0;
        rand_ready = 1'b0;
        exp_pc = pc_reset;
        repeat (reset_cycles) @(posedge clk);
        #5;
        rstn = 1'b1;
        test_stream();
        test_backpressure();
        test_redirect();
        test_ibar();
        test_csr_tlb();
        test_excp();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// ==== tb.f ====
hdl/fetch_pkg.sv
hdl/fetch_pc_gen.sv
hdl/fetch_stage_reg.sv
hdl/inst_queue.sv
hdl/decode_issue.sv
hdl/frontend_top.sv
tests/frontend_tb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = frontend_tb
FILELIST = tb.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
